// File: logic/exec_pkg.sv
// Shared widths, ROB index and exception types, control union, credit and FSM constants
package exec_pkg;

  //////////////////////////////////////////////////
  // Data and tag widths
  //////////////////////////////////////////////////

  localparam int unsigned XLEN = 64;
  typedef logic [XLEN-1:0] xlen_t;

  localparam int unsigned ROB_IDX_W = 4;
  typedef logic [ROB_IDX_W-1:0] rob_idx_t;

  // Width of the raw control word at issue
  localparam int unsigned EU_CTL_W = 4;

  // Only the codes this cluster can raise
  typedef enum logic [3:0] {
    E_NONE                = 4'h0,
    // Matches the mcause value for illegal instruction
    E_ILLEGAL_INSTRUCTION = 4'h2
  } except_code_t;

  //////////////////////////////////////////////////
  // Control word, one word and two decodings
  //////////////////////////////////////////////////

  typedef union packed {
    // Divide view, rsvd set means illegal
    struct packed {
      logic word_op;
      logic is_rem;
      logic is_unsigned;
      logic rsvd;
    } div;
    // Multiply view, every code legal
    struct packed {
      logic word_op;
      logic high;
      logic a_signed;
      logic b_signed;
    } mul;
  } eu_ctl_u;

  // Target unit of an issued operation
  typedef enum logic {
    EU_DIV = 1'b0,
    EU_MUL = 1'b1
  } eu_sel_t;

  //////////////////////////////////////////////////
  // Credits and internal sizes
  //////////////////////////////////////////////////

  localparam int unsigned DIV_CREDITS = 1;
  localparam int unsigned MUL_CREDITS = 2;
  localparam int unsigned CDB_CREDITS = 2;

  // One extra value so an overflow stays visible
  localparam int unsigned CDB_CNT_W = $clog2(CDB_CREDITS + 1);
  localparam int unsigned MUL_CNT_W = $clog2(MUL_CREDITS + 1);
  localparam int unsigned MUL_PTR_W = $clog2(MUL_CREDITS);

  // Serial divider iteration counter and states
  localparam int unsigned SD_CNT_W = $clog2(XLEN);
  localparam logic [1:0] SD_IDLE   = 2'd0;
  localparam logic [1:0] SD_DIVIDE = 2'd1;
  localparam logic [1:0] SD_DONE   = 2'd2;

endpackage

// File: logic/cdb_if.sv
// Result bundle interface between an execution unit and the CDB arbiter
`timescale 1ns/1ps

interface cdb_if;
  import exec_pkg::*;

  // Request and its acknowledge
  logic         valid;
  logic         grant;

  // Result bundle, stable while valid waits for grant
  rob_idx_t     rob_idx;
  xlen_t        result;
  logic         except_raised;
  except_code_t except_code;

  // Unit side drives the bundle
  modport unit (
    output valid,
    output rob_idx,
    output result,
    output except_raised,
    output except_code,
    input  grant
  );

  // Arbiter side picks a winner
  modport arb (
    input  valid,
    input  rob_idx,
    input  result,
    input  except_raised,
    input  except_code,
    output grant
  );

endinterface

// File: logic/serdiv.sv
// Serial restoring divider, one quotient bit per cycle, M-extension special cases
`timescale 1ns/1ps

module serdiv (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               in_valid_i,
  input  exec_pkg::xlen_t    op_a_i,
  input  exec_pkg::xlen_t    op_b_i,
  input  logic               signed_i,
  input  logic               rem_i,
  input  exec_pkg::rob_idx_t id_i,
  input  logic               out_grant_i,
  output logic               busy_o,
  output logic               out_valid_o,
  output exec_pkg::xlen_t    res_o,
  output exec_pkg::rob_idx_t id_o
);
  import exec_pkg::*;

  logic [1:0]          state_q, state_d;
  logic [SD_CNT_W-1:0] cnt_q;

  // Operation context, loaded at start
  xlen_t    a_q;
  xlen_t    b_mag_q;
  logic     neg_quo_q, neg_rem_q, rem_q;
  logic     zero_q, ovf_q;
  rob_idx_t id_q;

  // Iteration registers
  xlen_t    quo_q, acc_q, res_q;

  logic          sign_a, sign_b;
  xlen_t         a_mag, b_mag;
  logic [XLEN:0] trial;
  logic          fits;
  xlen_t         quo_next, acc_next, res_d;

  // Magnitudes of the incoming operands
  assign sign_a = signed_i & op_a_i[XLEN-1];
  assign sign_b = signed_i & op_b_i[XLEN-1];
  assign a_mag  = sign_a ? -op_a_i : op_a_i;
  assign b_mag  = sign_b ? -op_b_i : op_b_i;

  // Shift in next dividend bit, subtract when it fits
  assign trial    = {acc_q, quo_q[XLEN-1]};
  assign fits     = trial >= {1'b0, b_mag_q};
  assign acc_next = fits ? xlen_t'(trial - {1'b0, b_mag_q}) : trial[XLEN-1:0];
  assign quo_next = {quo_q[XLEN-2:0], fits};

  // Final value from the last iteration
  always_comb begin
    if (zero_q) begin
      // x / 0 is all ones, x % 0 is x
      res_d = rem_q ? a_q : '1;
    end else if (ovf_q) begin
      // Most negative / -1 keeps dividend, remainder 0
      res_d = rem_q ? '0 : a_q;
    end else if (rem_q) begin
      // Remainder takes the dividend sign
      res_d = neg_rem_q ? -acc_next : acc_next;
    end else begin
      res_d = neg_quo_q ? -quo_next : quo_next;
    end
  end

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      SD_IDLE:   if (in_valid_i) state_d = SD_DIVIDE;
      SD_DIVIDE: if (cnt_q == '0) state_d = SD_DONE;
      SD_DONE:   if (out_grant_i) state_d = SD_IDLE;
      default:   state_d = SD_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SD_IDLE;
      cnt_q   <= '0;
    end else if (flush_i) begin
      state_q <= SD_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == SD_IDLE) begin
        // XLEN iterations, counted down to zero
        cnt_q <= SD_CNT_W'(XLEN - 1);
      end else if (state_q == SD_DIVIDE) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == SD_IDLE && in_valid_i) begin
      a_q       <= op_a_i;
      b_mag_q   <= b_mag;
      quo_q     <= a_mag;
      acc_q     <= '0;
      neg_quo_q <= sign_a ^ sign_b;
      neg_rem_q <= sign_a;
      rem_q     <= rem_i;
      zero_q    <= op_b_i == '0;
      ovf_q     <= signed_i && op_a_i == {1'b1, {(XLEN-1){1'b0}}} && op_b_i == '1;
      id_q      <= id_i;
    end else if (state_q == SD_DIVIDE) begin
      quo_q <= quo_next;
      acc_q <= acc_next;
      if (cnt_q == '0) res_q <= res_d;
    end
  end

  assign busy_o      = state_q != SD_IDLE;
  assign out_valid_o = state_q == SD_DONE;
  assign res_o       = res_q;
  assign id_o        = id_q;

  // Caller must wait for the held result to leave
  a_no_start_busy: assert property (
    @(posedge clk_i) disable iff (!rst_ni) in_valid_i |-> !busy_o
  ) else $error("serdiv started while busy");

endmodule

// File: logic/div_unit.sv
// Divide unit with div-view decode, W operand prep, illegal check and serial divider
`timescale 1ns/1ps

module div_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               issue_valid_i,
  input  exec_pkg::eu_ctl_u  ctl_i,
  input  exec_pkg::rob_idx_t rob_idx_i,
  input  exec_pkg::xlen_t    rs1_i,
  input  exec_pkg::xlen_t    rs2_i,
  output logic               credit_o,
  cdb_if.unit                cdb
);
  import exec_pkg::*;

  xlen_t op_a, op_b;
  xlen_t div_res;
  logic  busy;

  // Flags travelling with the operation
  logic  word_q, illegal_q;

  // W forms use the low 32 bits, extended by signedness
  always_comb begin
    op_a = rs1_i;
    op_b = rs2_i;
    if (ctl_i.div.word_op) begin
      if (ctl_i.div.is_unsigned) begin
        op_a = {32'b0, rs1_i[31:0]};
        op_b = {32'b0, rs2_i[31:0]};
      end else begin
        op_a = {{32{rs1_i[31]}}, rs1_i[31:0]};
        op_b = {{32{rs2_i[31]}}, rs2_i[31:0]};
      end
    end
  end

  // Captured with the operands at start
  always_ff @(posedge clk_i) begin
    if (issue_valid_i && !busy) begin
      word_q    <= ctl_i.div.word_op;
      illegal_q <= ctl_i.div.rsvd;
    end
  end

  //////////////////////////////////////////////////
  // Divider core
  //////////////////////////////////////////////////

  // Illegal codes still run the full latency
  serdiv serdiv_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .in_valid_i  (issue_valid_i),
    .op_a_i      (op_a),
    .op_b_i      (op_b),
    .signed_i    (~ctl_i.div.is_unsigned),
    .rem_i       (ctl_i.div.is_rem),
    .id_i        (rob_idx_i),
    .out_grant_i (cdb.grant),
    .busy_o      (busy),
    .out_valid_o (cdb.valid),
    .res_o       (div_res),
    .id_o        (cdb.rob_idx)
  );

  // 32-bit results are always sign extended
  assign cdb.result = illegal_q ? '0 :
                      word_q    ? {{32{div_res[31]}}, div_res[31:0]} : div_res;

  assign cdb.except_raised = illegal_q;
  assign cdb.except_code   = illegal_q ? E_ILLEGAL_INSTRUCTION : E_NONE;

  // Slot frees when the result is taken by the arbiter
  assign credit_o = cdb.valid & cdb.grant;

  // Issuer credit count must cover the single slot
  a_div_no_overrun: assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_valid_i |-> (int'(busy) < DIV_CREDITS)
  ) else $error("div issue with no free slot");

endmodule

// File: logic/mul_unit.sv
// Two-stage multiply unit with two-entry result FIFO
`timescale 1ns/1ps

module mul_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               flush_i,
  input  logic               issue_valid_i,
  input  exec_pkg::eu_ctl_u  ctl_i,
  input  exec_pkg::rob_idx_t rob_idx_i,
  input  exec_pkg::xlen_t    rs1_i,
  input  exec_pkg::xlen_t    rs2_i,
  output logic               credit_o,
  cdb_if.unit                cdb
);
  import exec_pkg::*;

  // Stage 1, extended operands
  logic                     s1_valid_q, s1_word_q, s1_high_q;
  logic [XLEN:0]            s1_a_q, s1_b_q;
  rob_idx_t                 s1_rob_q;
  logic signed [2*XLEN+1:0] prod_full;

  // Stage 2, full product
  logic                     s2_valid_q, s2_word_q, s2_high_q;
  logic [2*XLEN-1:0]        s2_prod_q;
  rob_idx_t                 s2_rob_q;
  xlen_t                    s2_res;

  // Result FIFO
  xlen_t                    fifo_res_q [MUL_CREDITS];
  rob_idx_t                 fifo_rob_q [MUL_CREDITS];
  logic [MUL_PTR_W-1:0]     wr_ptr_q, rd_ptr_q;
  logic [MUL_CNT_W-1:0]     count_q;
  logic                     push, pop, stall;

  assign pop   = cdb.valid & cdb.grant;
  // Whole pipe holds while the FIFO cannot take more
  assign stall = (count_q == MUL_CNT_W'(MUL_CREDITS)) && !pop;
  assign push  = s2_valid_q & !stall;

  assign prod_full = $signed(s1_a_q) * $signed(s1_b_q);

  // W ignores high, low word sign extended
  assign s2_res = s2_word_q ? {{32{s2_prod_q[31]}}, s2_prod_q[31:0]} :
                  s2_high_q ? s2_prod_q[2*XLEN-1:XLEN] : s2_prod_q[XLEN-1:0];

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
    end else if (flush_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
    end else begin
      if (!stall) begin
        s1_valid_q <= issue_valid_i;
        s2_valid_q <= s1_valid_q;
      end
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_q + MUL_CNT_W'(push) - MUL_CNT_W'(pop);
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      // Extra top bit carries the operand sign
      s1_a_q    <= {ctl_i.mul.a_signed & rs1_i[XLEN-1], rs1_i};
      s1_b_q    <= {ctl_i.mul.b_signed & rs2_i[XLEN-1], rs2_i};
      s1_word_q <= ctl_i.mul.word_op;
      s1_high_q <= ctl_i.mul.high;
      s1_rob_q  <= rob_idx_i;
      s2_prod_q <= prod_full[2*XLEN-1:0];
      s2_word_q <= s1_word_q;
      s2_high_q <= s1_high_q;
      s2_rob_q  <= s1_rob_q;
    end
    if (push) begin
      fifo_res_q[wr_ptr_q] <= s2_res;
      fifo_rob_q[wr_ptr_q] <= s2_rob_q;
    end
  end

  // Head of the FIFO faces the arbiter
  assign cdb.valid         = count_q != '0;
  assign cdb.result        = fifo_res_q[rd_ptr_q];
  assign cdb.rob_idx       = fifo_rob_q[rd_ptr_q];
  assign cdb.except_raised = 1'b0;
  assign cdb.except_code   = E_NONE;

  assign credit_o = pop;

  // Ops anywhere in the unit bounded by issuer credits
  a_mul_no_overrun: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_valid_i |-> (int'(s1_valid_q) + int'(s2_valid_q) + int'(count_q) < MUL_CREDITS)
  ) else $error("mul issue with all slots full");

endmodule

// File: logic/cdb_arbiter.sv
// Round-robin CDB arbiter with credit counter and registered CDB output
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   flush_i,
  input  logic                   cdb_credit_i,
  cdb_if.arb                     div_req,
  cdb_if.arb                     mul_req,
  output logic                   cdb_valid_o,
  output exec_pkg::rob_idx_t     cdb_rob_idx_o,
  output exec_pkg::xlen_t        cdb_result_o,
  output logic                   cdb_except_o,
  output exec_pkg::except_code_t cdb_except_code_o
);
  import exec_pkg::*;

  logic [CDB_CNT_W-1:0] credit_q;
  logic                 last_mul_q;
  logic                 can_grant, take;

  // No transfers during a flush or without credit
  assign can_grant = (credit_q != '0) && !flush_i;

  // Mul wins ties unless it won last time
  assign div_req.grant = can_grant & div_req.valid & (~mul_req.valid | last_mul_q);
  assign mul_req.grant = can_grant & mul_req.valid & (~div_req.valid | ~last_mul_q);
  assign take          = div_req.grant | mul_req.grant;

  //////////////////////////////////////////////////
  // Credits and fairness
  //////////////////////////////////////////////////

  // Credit spent as the output register loads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q    <= CDB_CNT_W'(CDB_CREDITS);
      last_mul_q  <= 1'b0;
      cdb_valid_o <= 1'b0;
    end else if (flush_i) begin
      credit_q    <= CDB_CNT_W'(CDB_CREDITS);
      last_mul_q  <= 1'b0;
      cdb_valid_o <= 1'b0;
    end else begin
      credit_q    <= credit_q - CDB_CNT_W'(take) + CDB_CNT_W'(cdb_credit_i);
      cdb_valid_o <= take;
      if (take) last_mul_q <= mul_req.grant;
    end
  end

  // Winner bundle
  always_ff @(posedge clk_i) begin
    if (div_req.grant) begin
      cdb_rob_idx_o     <= div_req.rob_idx;
      cdb_result_o      <= div_req.result;
      cdb_except_o      <= div_req.except_raised;
      cdb_except_code_o <= div_req.except_code;
    end else if (mul_req.grant) begin
      cdb_rob_idx_o     <= mul_req.rob_idx;
      cdb_result_o      <= mul_req.result;
      cdb_except_o      <= mul_req.except_raised;
      cdb_except_code_o <= mul_req.except_code;
    end
  end

  // Consumer never returns more than it was given
  a_cdb_credit_bound: assert property (
    @(posedge clk_i) disable iff (!rst_ni) credit_q <= CDB_CREDITS
  ) else $error("CDB credit counter overflow");

endmodule

// File: logic/exec_cluster.sv
// Execution cluster top with divide and multiply units sharing the CDB
`timescale 1ns/1ps

module exec_cluster (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  // Issue
  input  logic                          issue_valid_i,
  input  exec_pkg::eu_sel_t             issue_eu_i,
  input  logic [exec_pkg::EU_CTL_W-1:0] issue_ctl_i,
  input  exec_pkg::rob_idx_t            issue_rob_idx_i,
  input  exec_pkg::xlen_t               issue_rs1_i,
  input  exec_pkg::xlen_t               issue_rs2_i,
  // Issue credits back to the issuer
  output logic                          div_credit_o,
  output logic                          mul_credit_o,
  // CDB
  input  logic                          cdb_credit_i,
  output logic                          cdb_valid_o,
  output exec_pkg::rob_idx_t            cdb_rob_idx_o,
  output exec_pkg::xlen_t               cdb_result_o,
  output logic                          cdb_except_o,
  output exec_pkg::except_code_t        cdb_except_code_o
);
  import exec_pkg::*;

  eu_ctl_u issue_ctl;
  logic    div_issue, mul_issue;

  // Same word decoded by each unit in its own view
  assign issue_ctl = eu_ctl_u'(issue_ctl_i);
  assign div_issue = issue_valid_i && (issue_eu_i == EU_DIV);
  assign mul_issue = issue_valid_i && (issue_eu_i == EU_MUL);

  cdb_if div_cdb ();
  cdb_if mul_cdb ();

  div_unit div_unit_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_valid_i (div_issue),
    .ctl_i         (issue_ctl),
    .rob_idx_i     (issue_rob_idx_i),
    .rs1_i         (issue_rs1_i),
    .rs2_i         (issue_rs2_i),
    .credit_o      (div_credit_o),
    .cdb           (div_cdb.unit)
  );

  mul_unit mul_unit_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .issue_valid_i (mul_issue),
    .ctl_i         (issue_ctl),
    .rob_idx_i     (issue_rob_idx_i),
    .rs1_i         (issue_rs1_i),
    .rs2_i         (issue_rs2_i),
    .credit_o      (mul_credit_o),
    .cdb           (mul_cdb.unit)
  );

  cdb_arbiter cdb_arbiter_i (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .flush_i           (flush_i),
    .cdb_credit_i      (cdb_credit_i),
    .div_req           (div_cdb.arb),
    .mul_req           (mul_cdb.arb),
    .cdb_valid_o       (cdb_valid_o),
    .cdb_rob_idx_o     (cdb_rob_idx_o),
    .cdb_result_o      (cdb_result_o),
    .cdb_except_o      (cdb_except_o),
    .cdb_except_code_o (cdb_except_code_o)
  );

endmodule

// File: sim/tb_clock.sv
// Testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset low for five cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: sim/exec_cluster_tb.sv
// Execution cluster testbench with stimulus, credit tracking, reference model, scoreboard and checks
`timescale 1ns/1ps

module exec_cluster_tb;
  import exec_pkg::*;

  localparam int ROB_N       = 1 << ROB_IDX_W;
  localparam int WAIT_LIMIT  = 4000;
  localparam int ISSUE_LIMIT = 400;

  logic         clk, rst_n;
  logic         flush_i, issue_valid_i, cdb_credit_i;
  eu_sel_t      issue_eu_i;
  logic [3:0]   issue_ctl_i;
  rob_idx_t     issue_rob_idx_i;
  xlen_t        issue_rs1_i, issue_rs2_i;
  logic         div_credit_o, mul_credit_o;
  logic         cdb_valid_o, cdb_except_o;
  rob_idx_t     cdb_rob_idx_o;
  xlen_t        cdb_result_o;
  except_code_t cdb_except_code_o;

  // Scoreboard with one entry per ROB index
  logic         exp_valid [ROB_N];
  xlen_t        exp_res   [ROB_N];
  except_code_t exp_code  [ROB_N];
  string        exp_name  [ROB_N];

  integer   seed = 75;
  string    test_name = "reset";
  rob_idx_t next_rob = '0;
  rob_idx_t mon_idx;
  // Issuer credits, CDB credits owed back, progress counts
  int       div_cred = DIV_CREDITS;
  int       mul_cred = MUL_CREDITS;
  int       owed_cdb = 0;
  int       pending = 0;
  int       n_seen = 0;
  logic     ret_en = 1'b1;

  tb_clock tb_clock_i (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  exec_cluster exec_cluster_i (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .flush_i           (flush_i),
    .issue_valid_i     (issue_valid_i),
    .issue_eu_i        (issue_eu_i),
    .issue_ctl_i       (issue_ctl_i),
    .issue_rob_idx_i   (issue_rob_idx_i),
    .issue_rs1_i       (issue_rs1_i),
    .issue_rs2_i       (issue_rs2_i),
    .div_credit_o      (div_credit_o),
    .mul_credit_o      (mul_credit_o),
    .cdb_credit_i      (cdb_credit_i),
    .cdb_valid_o       (cdb_valid_o),
    .cdb_rob_idx_o     (cdb_rob_idx_o),
    .cdb_result_o      (cdb_result_o),
    .cdb_except_o      (cdb_except_o),
    .cdb_except_code_o (cdb_except_code_o)
  );

  //////////////////////////////////////////////////
  // Failure handling and compare tasks
  //////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_result(input string name, input xlen_t exp, input xlen_t act);
    if (act !== exp) abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic check_except(input string name, input except_code_t exp,
                              input except_code_t act);
    if (act !== exp)
      abort_run($sformatf("error %s: expected code %h, actual %h", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
  endtask

  //////////////////////////////////////////////////
  // Reference model from the M-extension rules
  //////////////////////////////////////////////////

  function automatic xlen_t div_rule(input xlen_t x, input xlen_t y, input logic sgn,
                                     input logic rem);
    // Zero divisor and signed overflow never trap
    if (y == '0) return rem ? x : '1;
    if (sgn && x == {1'b1, {(XLEN-1){1'b0}}} && y == '1) return rem ? '0 : x;
    if (sgn) return rem ? xlen_t'($signed(x) % $signed(y)) : xlen_t'($signed(x) / $signed(y));
    return rem ? x % y : x / y;
  endfunction

  // Bit 3 selects the W form
  // Low bits are mul {high, a_signed, b_signed} or div {rem, unsigned, rsvd}
  function automatic void ref_exec(input eu_sel_t eu, input logic [3:0] ctl, input xlen_t a,
                                   input xlen_t b, output xlen_t res, output except_code_t code);
    logic [2*XLEN+1:0] ea, eb, prod;
    xlen_t             x, y, r;
    code = E_NONE;
    if (eu == EU_MUL) begin
      ea   = ctl[1] ? {{(XLEN+2){a[XLEN-1]}}, a} : {{(XLEN+2){1'b0}}, a};
      eb   = ctl[0] ? {{(XLEN+2){b[XLEN-1]}}, b} : {{(XLEN+2){1'b0}}, b};
      prod = ea * eb;
      res  = ctl[3] ? {{32{prod[31]}}, prod[31:0]} :
             ctl[2] ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
    end else if (ctl[0]) begin
      res  = '0;
      code = E_ILLEGAL_INSTRUCTION;
    end else begin
      x = a;
      y = b;
      if (ctl[3]) begin
        x = ctl[1] ? {32'b0, a[31:0]} : {{32{a[31]}}, a[31:0]};
        y = ctl[1] ? {32'b0, b[31:0]} : {{32{b[31]}}, b[31:0]};
      end
      r   = div_rule(x, y, !ctl[1], ctl[2]);
      res = ctl[3] ? {{32{r[31]}}, r[31:0]} : r;
    end
  endfunction

  // Corner values and random words with dirty upper halves
  function automatic xlen_t pick_operand();
    int sel;
    sel = $random(seed) & 7;
    case (sel)
      0:       return '0;
      1:       return '1;
      2:       return {1'b1, {(XLEN-1){1'b0}}};
      3:       return {$random(seed), 32'h8000_0000};
      4:       return {$random(seed), 32'hffff_ffff};
      default: return {$random(seed), $random(seed)};
    endcase
  endfunction

  //////////////////////////////////////////////////
  // Issue and wait helpers
  //////////////////////////////////////////////////

  // Starts on a falling edge and ends on the next one
  task automatic issue_op(input eu_sel_t eu, input logic [3:0] ctl, input xlen_t a,
                          input xlen_t b);
    int           waited;
    xlen_t        res;
    except_code_t code;
    waited = 0;
    while ((eu == EU_DIV ? div_cred : mul_cred) == 0 || exp_valid[next_rob]) begin
      @(negedge clk);
      waited++;
      if (waited > ISSUE_LIMIT) abort_run("timeout waiting for an issue credit or free ROB tag");
    end
    ref_exec(eu, ctl, a, b, res, code);
    exp_valid[next_rob] = 1'b1;
    exp_res[next_rob]   = res;
    exp_code[next_rob]  = code;
    exp_name[next_rob]  = test_name;
    if (eu == EU_DIV) div_cred--;
    else mul_cred--;
    pending++;
    issue_valid_i   = 1'b1;
    issue_eu_i      = eu;
    issue_ctl_i     = ctl;
    issue_rob_idx_i = next_rob;
    issue_rs1_i     = a;
    issue_rs2_i     = b;
    next_rob        = next_rob + 1'b1;
    @(negedge clk);
    issue_valid_i = 1'b0;
  endtask

  // Waits for all results and CDB credits, then checks issuer credits
  task automatic wait_idle();
    int n;
    n = 0;
    while (pending != 0 || owed_cdb != 0) begin
      @(negedge clk);
      n++;
      if (n > WAIT_LIMIT) abort_run("timeout waiting for outstanding results");
    end
    repeat (2) @(negedge clk);
    if (div_cred != DIV_CREDITS)
      abort_run($sformatf("error %s: expected div credits %0d, actual %0d",
                          test_name, DIV_CREDITS, div_cred));
    if (mul_cred != MUL_CREDITS)
      abort_run($sformatf("error %s: expected mul credits %0d, actual %0d",
                          test_name, MUL_CREDITS, mul_cred));
  endtask

  task automatic wait_results(input int count);
    int base;
    int n;
    base = n_seen;
    n = 0;
    while (n_seen < base + count) begin
      @(negedge clk);
      n++;
      if (n > ISSUE_LIMIT) abort_run("timeout waiting for results on the CDB");
    end
  endtask

  // Flush drops every pending entry with no credit pulses
  task automatic flush_cluster();
    int i;
    flush_i = 1'b1;
    @(negedge clk);
    flush_i = 1'b0;
    for (i = 0; i < ROB_N; i++) exp_valid[i] = 1'b0;
    pending  = 0;
    owed_cdb = 0;
    div_cred = DIV_CREDITS;
    mul_cred = MUL_CREDITS;
  endtask

  //////////////////////////////////////////////////
  // Monitor and CDB credit return
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (div_credit_o) div_cred++;
      if (mul_credit_o) mul_cred++;
      if (div_cred > DIV_CREDITS || mul_cred > MUL_CREDITS)
        abort_run("issue credit returned with no slot in use");
      if (cdb_valid_o) begin
        mon_idx = cdb_rob_idx_o;
        if (!exp_valid[mon_idx])
          abort_run($sformatf("result on ROB index %0d with no operation pending", mon_idx));
        check_result(exp_name[mon_idx], exp_res[mon_idx], cdb_result_o);
        check_except(exp_name[mon_idx], exp_code[mon_idx], cdb_except_code_o);
        check_flag(exp_name[mon_idx], exp_code[mon_idx] != E_NONE, cdb_except_o);
        exp_valid[mon_idx] = 1'b0;
        pending--;
        n_seen++;
        owed_cdb++;
        // Consumer never holds more than it was given
        if (owed_cdb > CDB_CREDITS) abort_run("more CDB results than CDB credits");
      end
    end
  end

  // One credit back per cycle while enabled
  always @(negedge clk) begin
    if (rst_n && ret_en && owed_cdb > 0) begin
      cdb_credit_i = 1'b1;
      owed_cdb--;
    end else begin
      cdb_credit_i = 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin : main
    int c;
    int n;
    int base;
    for (c = 0; c < ROB_N; c++) exp_valid[c] = 1'b0;
    flush_i         = 1'b0;
    issue_valid_i   = 1'b0;
    issue_eu_i      = EU_DIV;
    issue_ctl_i     = '0;
    issue_rob_idx_i = '0;
    issue_rs1_i     = '0;
    issue_rs2_i     = '0;
    cdb_credit_i    = 1'b0;

    n = 0;
    while (!rst_n) begin
      @(negedge clk);
      n++;
      if (n > 20) abort_run("reset was never released");
    end
    @(negedge clk);
    check_flag("reset", 1'b0, cdb_valid_o);
    check_flag("reset", 1'b0, div_credit_o);
    check_flag("reset", 1'b0, mul_credit_o);

    // Every sign, half and width combination
    test_name = "mul";
    for (c = 0; c < 16; c++) begin
      repeat (4) issue_op(EU_MUL, 4'(c), pick_operand(), pick_operand());
    end
    wait_idle();

    // Legal div codes with zero divisor and overflow
    test_name = "div";
    for (c = 0; c < 8; c++) begin
      issue_op(EU_DIV, {3'(c), 1'b0}, pick_operand(), '0);
      issue_op(EU_DIV, {3'(c), 1'b0}, {1'b1, {(XLEN-1){1'b0}}}, '1);
      issue_op(EU_DIV, {3'(c), 1'b0}, {$random(seed), 32'h8000_0000},
               {$random(seed), 32'hffff_ffff});
      repeat (2) issue_op(EU_DIV, {3'(c), 1'b0}, pick_operand(), pick_operand());
    end
    wait_idle();

    test_name = "illegal";
    repeat (4) issue_op(EU_DIV, {3'($random(seed)), 1'b1}, pick_operand(), pick_operand());
    wait_idle();

    // Multiplies stream past each running divide
    test_name = "mixed";
    repeat (4) begin
      issue_op(EU_DIV, {3'($random(seed)), 1'b0}, pick_operand(), pick_operand());
      repeat (6) issue_op(EU_MUL, 4'($random(seed)), pick_operand(), pick_operand());
    end
    wait_idle();

    // Consumer withholds credits
    test_name = "backpressure";
    ret_en = 1'b0;
    base = n_seen;
    issue_op(EU_DIV, {3'($random(seed)), 1'b0}, pick_operand(), pick_operand());
    repeat (2) issue_op(EU_MUL, 4'($random(seed)), pick_operand(), pick_operand());
    repeat (XLEN + 40) @(negedge clk);
    if (n_seen - base != CDB_CREDITS)
      abort_run($sformatf("error %s: expected %0d results, actual %0d",
                          test_name, CDB_CREDITS, n_seen - base));
    ret_en = 1'b1;
    wait_idle();

    // Flush with a divide running and multiplies stuck behind the CDB
    test_name = "flush";
    ret_en = 1'b0;
    repeat (2) issue_op(EU_MUL, 4'($random(seed)), pick_operand(), pick_operand());
    wait_results(2);
    issue_op(EU_DIV, {3'($random(seed)), 1'b0}, pick_operand(), pick_operand());
    repeat (2) issue_op(EU_MUL, 4'($random(seed)), pick_operand(), pick_operand());
    repeat (20) @(negedge clk);
    flush_cluster();
    // Any result now hits an empty scoreboard entry
    repeat (XLEN + 40) @(negedge clk);
    ret_en = 1'b1;
    test_name = "after_flush";
    issue_op(EU_DIV, {3'($random(seed)), 1'b0}, pick_operand(), pick_operand());
    repeat (4) issue_op(EU_MUL, 4'($random(seed)), pick_operand(), pick_operand());
    issue_op(EU_DIV, {3'($random(seed)), 1'b0}, pick_operand(), pick_operand());
    wait_idle();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: tb.f
logic/exec_pkg.sv
logic/cdb_if.sv
logic/serdiv.sv
logic/div_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/exec_cluster.sv
sim/tb_clock.sv
sim/exec_cluster_tb.sv

// File: Bender.yml
package:
  name: exec_cluster

sources:
  - logic/exec_pkg.sv
  - logic/cdb_if.sv
  - logic/serdiv.sv
  - logic/div_unit.sv
  - logic/mul_unit.sv
  - logic/cdb_arbiter.sv
  - logic/exec_cluster.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/exec_cluster_tb.sv
